//--- logic/pkt_pkg.sv
// packet beat and command layouts shared by buffers, arbiter and master
// producers must keep a whole packet within MAX_BEATS beats
`default_nettype none

package pkt_pkg;

    // data beat: payload, residue, start flag, end flag
    localparam int DAT_W     = 36;
    localparam int PAYLOAD_W = 32;
    localparam int RES_LSB   = 32;
    localparam int RES_W     = 2;
    localparam int SOP_BIT   = 34;
    localparam int EOP_BIT   = 35;

    // command word, bits 55..51 reserved
    localparam int CMD_W        = 56;
    localparam int CMD_ADDR_LSB = 0;
    localparam int CMD_ADDR_W   = 36;
    localparam int CMD_ID_LSB   = 36;
    localparam int CMD_ID_W     = 4;
    localparam int CMD_SIZE_LSB = 40;
    localparam int CMD_SIZE_W   = 3;
    localparam int CMD_LEN_LSB  = 43;
    localparam int CMD_LEN_W    = 8;

    // buffer sizing
    localparam int FIFO_AW   = 4;
    localparam int AFULL_THD = 12;
    localparam int MAX_BEATS = 4;

endpackage

`default_nettype wire

//--- logic/axi_pkg.sv
// AXI4 write channel widths for the 32-bit DDR port
`default_nettype none

package axi_pkg;

    localparam int AXI_ADDR_W = 64;
    localparam int AXI_ID_W   = 4;
    localparam int AXI_LEN_W  = 8;
    localparam int AXI_SIZE_W = 3;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = 4;
    localparam int AXI_RESP_W = 2;

endpackage

`default_nettype wire

//--- logic/pkt_ifs.sv
// show-ahead reads: data is valid while empty is low, a read pops that cycle
// merged writes have no acknowledge, the arbiter guarantees room
`default_nettype none

interface src_if;
    import pkt_pkg::*;

    logic             cmd_empty;
    logic [CMD_W-1:0] cmd_data;
    logic             cmd_rd;
    logic             dat_empty;
    logic [DAT_W-1:0] dat_data;
    logic             dat_rd;

    modport buffer (output cmd_empty, cmd_data, dat_empty, dat_data, input cmd_rd, dat_rd);
    modport arbiter (input cmd_empty, cmd_data, dat_empty, dat_data, output cmd_rd, dat_rd);
endinterface

interface merge_if;
    import pkt_pkg::*;

    logic             cmd_wr;
    logic [CMD_W-1:0] cmd_data;
    logic             dat_wr;
    logic [DAT_W-1:0] dat_data;
    logic             dat_afull;
    logic             cmd_empty;

    modport arbiter (output cmd_wr, cmd_data, dat_wr, dat_data, input dat_afull, cmd_empty);
    modport master (input cmd_wr, cmd_data, dat_wr, dat_data, output dat_afull, cmd_empty);
endinterface

`default_nettype wire

//--- logic/sync_fifo.sv
// show-ahead FIFO of 2**FIFO_AW entries, head always on rdata
// no overflow or underflow protection, callers keep to afull and empty
`default_nettype none

module sync_fifo #(
    parameter int WIDTH     = 8,
    parameter int AFULL_THD = pkt_pkg::AFULL_THD
) (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             wr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             rd,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             afull
);
    import pkt_pkg::*;

    logic [WIDTH-1:0]   mem [2**FIFO_AW];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign afull = (count >= AFULL_THD);

endmodule

`default_nettype wire

//--- logic/src_buffer.sv
// the producer's start bit is ignored and rebuilt from the end flags
// writes must stop while the matching afull flag is high
`default_nettype none

module src_buffer (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      cmd_wr,
    input  logic [pkt_pkg::CMD_W-1:0] cmd_data,
    input  logic                      dat_wr,
    input  logic [pkt_pkg::DAT_W-1:0] dat_data,
    output logic                      cmd_afull,
    output logic                      dat_afull,
    src_if.buffer                     src
);
    import pkt_pkg::*;

    logic             sop_lock;
    logic [DAT_W-1:0] dat_marked;

    // next beat starts a packet after reset or after an end beat
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            sop_lock <= 1'b1;
        end else if (dat_wr) begin
            sop_lock <= dat_data[EOP_BIT];
        end
    end

    always_comb begin
        dat_marked          = dat_data;
        dat_marked[SOP_BIT] = sop_lock;
    end

    sync_fifo #(.WIDTH(CMD_W)) u_cmd_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (cmd_wr),
        .wdata   (cmd_data),
        .rd      (src.cmd_rd),
        .rdata   (src.cmd_data),
        .empty   (src.cmd_empty),
        .afull   (cmd_afull)
    );

    sync_fifo #(.WIDTH(DAT_W)) u_dat_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (dat_wr),
        .wdata   (dat_marked),
        .rd      (src.dat_rd),
        .rdata   (src.dat_data),
        .empty   (src.dat_empty),
        .afull   (dat_afull)
    );

endmodule

`default_nettype wire

//--- logic/wr_arbiter.sv
// moves one whole packet per grant, grants spaced by at least three cycles
// a granted source with no data yet simply waits for its beats
`default_nettype none

module wr_arbiter (
    input  logic     clk_sys,
    input  logic     rst,
    input  logic     sel_afull,
    output logic     sel_wr,
    output logic     sel_src,
    src_if.arbiter   tx,
    src_if.arbiter   kernel,
    merge_if.arbiter merge
);
    import pkt_pkg::*;

    logic grant;
    logic grant_d1;
    logic grant_d2;
    logic grant_sel;
    logic rr_ptr;
    logic tx_act;
    logic kernel_act;
    logic tx_req;
    logic kernel_req;
    logic grant_ok;

    // ************************************************************************
    // grant gating and round robin
    // ************************************************************************
    assign tx_req     = ~tx.cmd_empty;
    assign kernel_req = ~kernel.cmd_empty;
    assign grant_ok   = ~tx_act & ~kernel_act & (tx_req | kernel_req) &
                        ~grant_d1 & ~grant_d2 & ~merge.dat_afull & ~sel_afull;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            grant     <= 1'b0;
            grant_d1  <= 1'b0;
            grant_d2  <= 1'b0;
            grant_sel <= 1'b0;
            rr_ptr    <= 1'b0;
        end else begin
            grant    <= ~grant & grant_ok;
            grant_d1 <= grant;
            grant_d2 <= grant_d1;
            if (~grant & grant_ok) begin
                if (tx_req & kernel_req) begin
                    grant_sel <= rr_ptr;
                    rr_ptr    <= ~rr_ptr;
                end else begin
                    grant_sel <= kernel_req;
                end
            end
        end
    end

    // one record per packet, 1 means kernel
    assign sel_wr  = grant;
    assign sel_src = grant_sel;

    // ************************************************************************
    // packet reads, stopped by the end beat
    // ************************************************************************
    assign tx.dat_rd     = tx_act & ~tx.dat_empty;
    assign tx.cmd_rd     = tx.dat_rd & tx.dat_data[SOP_BIT];
    assign kernel.dat_rd = kernel_act & ~kernel.dat_empty;
    assign kernel.cmd_rd = kernel.dat_rd & kernel.dat_data[SOP_BIT];

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            tx_act     <= 1'b0;
            kernel_act <= 1'b0;
        end else begin
            if (tx.dat_rd & tx.dat_data[EOP_BIT]) begin
                tx_act <= 1'b0;
            end else if (grant & ~grant_sel) begin
                tx_act <= 1'b1;
            end
            if (kernel.dat_rd & kernel.dat_data[EOP_BIT]) begin
                kernel_act <= 1'b0;
            end else if (grant & grant_sel) begin
                kernel_act <= 1'b1;
            end
        end
    end

    // merged stage, one cycle behind the pops
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            merge.cmd_wr <= 1'b0;
            merge.dat_wr <= 1'b0;
        end else begin
            merge.cmd_wr <= tx.cmd_rd | kernel.cmd_rd;
            merge.dat_wr <= tx.dat_rd | kernel.dat_rd;
        end
    end

    always_ff @(posedge clk_sys) begin
        merge.cmd_data <= tx.cmd_rd ? tx.cmd_data : kernel.cmd_data;
        merge.dat_data <= tx.dat_rd ? tx.dat_data : kernel.dat_data;
    end

endmodule

`default_nettype wire

//--- logic/axi_wr_master.sv
// one AW per packet, then its W beats; AW and W never overlap
// a residue of 0 on the end beat means all four bytes are valid
`default_nettype none

module axi_wr_master (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             awready,
    input  logic                             wready,
    output logic                             awvalid,
    output logic [axi_pkg::AXI_ID_W-1:0]     awid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]   awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]    awlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]   awsize,
    output logic                             wvalid,
    output logic [axi_pkg::AXI_DATA_W-1:0]   wdata,
    output logic [axi_pkg::AXI_STRB_W-1:0]   wstrb,
    output logic                             wlast,
    merge_if.master                          merge
);
    import pkt_pkg::*;
    import axi_pkg::*;

    logic [CMD_W-1:0] cmd_head;
    logic             cmd_rd;
    logic [DAT_W-1:0] dat_head;
    logic             dat_empty;
    logic             dat_rd;
    logic             data_phase;
    logic [RES_W-1:0] res;

    sync_fifo #(.WIDTH(CMD_W)) u_cmd_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (merge.cmd_wr),
        .wdata   (merge.cmd_data),
        .rd      (cmd_rd),
        .rdata   (cmd_head),
        .empty   (merge.cmd_empty),
        .afull   ()
    );

    sync_fifo #(.WIDTH(DAT_W)) u_dat_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (merge.dat_wr),
        .wdata   (merge.dat_data),
        .rd      (dat_rd),
        .rdata   (dat_head),
        .empty   (dat_empty),
        .afull   (merge.dat_afull)
    );

    // ************************************************************************
    // address phase
    // ************************************************************************
    assign awid   = cmd_head[CMD_ID_LSB +: CMD_ID_W];
    assign awaddr = {{(AXI_ADDR_W - CMD_ADDR_W){1'b0}}, cmd_head[CMD_ADDR_LSB +: CMD_ADDR_W]};
    assign awlen  = cmd_head[CMD_LEN_LSB +: CMD_LEN_W];
    assign awsize = cmd_head[CMD_SIZE_LSB +: CMD_SIZE_W];
    assign cmd_rd = awvalid & awready;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            awvalid    <= 1'b0;
            data_phase <= 1'b0;
        end else if (!data_phase) begin
            if (awvalid & awready) begin
                awvalid    <= 1'b0;
                data_phase <= 1'b1;
            end else if (~merge.cmd_empty & ~dat_empty & dat_head[SOP_BIT]) begin
                awvalid <= 1'b1;
            end
        end else if (dat_rd & wlast) begin
            data_phase <= 1'b0;
        end
    end

    // ************************************************************************
    // data phase
    // ************************************************************************
    assign wvalid = data_phase & ~dat_empty;
    assign wdata  = dat_head[PAYLOAD_W-1:0];
    assign wlast  = dat_head[EOP_BIT];
    assign dat_rd = wvalid & wready;
    assign res    = dat_head[RES_LSB +: RES_W];

    // low bytes only on a short end beat
    always_comb begin
        wstrb = '1;
        if (wlast) begin
            case (res)
                2'd1:    wstrb = 4'b0001;
                2'd2:    wstrb = 4'b0011;
                2'd3:    wstrb = 4'b0111;
                default: wstrb = 4'b1111;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/resp_router.sv
// responses return in grant order, bid is copied and not decoded
// bvalid pulses have no back-pressure
`default_nettype none

module resp_router (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             sel_wr,
    input  logic                             sel_src,
    input  logic                             bvalid,
    input  logic [axi_pkg::AXI_ID_W-1:0]     bid,
    input  logic [axi_pkg::AXI_RESP_W-1:0]   bresp,
    output logic                             bready,
    output logic                             sel_afull,
    output logic                             tx_bvalid,
    output logic                             kernel_bvalid,
    output logic [axi_pkg::AXI_ID_W-1:0]     rsp_bid,
    output logic [axi_pkg::AXI_RESP_W-1:0]   rsp_bresp
);
    logic rec_src;
    logic rec_empty;
    logic b_hs;

    // source of each granted packet, 1 is kernel
    sync_fifo #(.WIDTH(1)) u_sel_fifo (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wr      (sel_wr),
        .wdata   (sel_src),
        .rd      (b_hs),
        .rdata   (rec_src),
        .empty   (rec_empty),
        .afull   (sel_afull)
    );

    assign bready = ~rec_empty;
    assign b_hs   = bvalid & bready;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            tx_bvalid     <= 1'b0;
            kernel_bvalid <= 1'b0;
            rsp_bid       <= '0;
            rsp_bresp     <= '0;
        end else begin
            tx_bvalid     <= b_hs & ~rec_src;
            kernel_bvalid <= b_hs & rec_src;
            rsp_bid       <= bid;
            rsp_bresp     <= bresp;
        end
    end

endmodule

`default_nettype wire

//--- logic/pkt2ddr_top.sv
// two-source packet write merger onto one AXI4 write port
// producers write only while the matching afull flag is low
`default_nettype none

module pkt2ddr_top (
    input  logic                             clk_sys,
    input  logic                             rst,
    // tx producer
    input  logic                             tx_cmd_wr,
    input  logic [pkt_pkg::CMD_W-1:0]        tx_cmd_data,
    input  logic                             tx_dat_wr,
    input  logic [pkt_pkg::DAT_W-1:0]        tx_dat_data,
    output logic                             tx_cmd_afull,
    output logic                             tx_dat_afull,
    output logic                             tx_bvalid,
    output logic [axi_pkg::AXI_ID_W-1:0]     tx_bid,
    output logic [axi_pkg::AXI_RESP_W-1:0]   tx_bresp,
    // kernel producer
    input  logic                             kernel_cmd_wr,
    input  logic [pkt_pkg::CMD_W-1:0]        kernel_cmd_data,
    input  logic                             kernel_dat_wr,
    input  logic [pkt_pkg::DAT_W-1:0]        kernel_dat_data,
    output logic                             kernel_cmd_afull,
    output logic                             kernel_dat_afull,
    output logic                             kernel_bvalid,
    output logic [axi_pkg::AXI_ID_W-1:0]     kernel_bid,
    output logic [axi_pkg::AXI_RESP_W-1:0]   kernel_bresp,
    // AXI4 write
    output logic                             awvalid,
    input  logic                             awready,
    output logic [axi_pkg::AXI_ID_W-1:0]     awid,
    output logic [axi_pkg::AXI_ADDR_W-1:0]   awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]    awlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0]   awsize,
    output logic                             wvalid,
    input  logic                             wready,
    output logic [axi_pkg::AXI_DATA_W-1:0]   wdata,
    output logic [axi_pkg::AXI_STRB_W-1:0]   wstrb,
    output logic                             wlast,
    input  logic                             bvalid,
    output logic                             bready,
    input  logic [axi_pkg::AXI_ID_W-1:0]     bid,
    input  logic [axi_pkg::AXI_RESP_W-1:0]   bresp
);
    logic sel_wr;
    logic sel_src;
    logic sel_afull;

    src_if   tx_if ();
    src_if   kernel_if ();
    merge_if merge ();

    // ************************************************************************
    // source buffers
    // ************************************************************************
    src_buffer u_tx_buf (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .cmd_wr    (tx_cmd_wr),
        .cmd_data  (tx_cmd_data),
        .dat_wr    (tx_dat_wr),
        .dat_data  (tx_dat_data),
        .cmd_afull (tx_cmd_afull),
        .dat_afull (tx_dat_afull),
        .src       (tx_if.buffer)
    );

    src_buffer u_kernel_buf (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .cmd_wr    (kernel_cmd_wr),
        .cmd_data  (kernel_cmd_data),
        .dat_wr    (kernel_dat_wr),
        .dat_data  (kernel_dat_data),
        .cmd_afull (kernel_cmd_afull),
        .dat_afull (kernel_dat_afull),
        .src       (kernel_if.buffer)
    );

    // ************************************************************************
    // merge, AXI master and response steering
    // ************************************************************************
    wr_arbiter u_arbiter (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .sel_afull (sel_afull),
        .sel_wr    (sel_wr),
        .sel_src   (sel_src),
        .tx        (tx_if.arbiter),
        .kernel    (kernel_if.arbiter),
        .merge     (merge.arbiter)
    );

    axi_wr_master u_master (
        .clk_sys (clk_sys),
        .rst     (rst),
        .awready (awready),
        .wready  (wready),
        .awvalid (awvalid),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .merge   (merge.master)
    );

    resp_router u_router (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .sel_wr        (sel_wr),
        .sel_src       (sel_src),
        .bvalid        (bvalid),
        .bid           (bid),
        .bresp         (bresp),
        .bready        (bready),
        .sel_afull     (sel_afull),
        .tx_bvalid     (tx_bvalid),
        .kernel_bvalid (kernel_bvalid),
        .rsp_bid       (tx_bid),
        .rsp_bresp     (tx_bresp)
    );

    // both sources see the same registered id and status
    assign kernel_bid   = tx_bid;
    assign kernel_bresp = tx_bresp;

endmodule

`default_nettype wire

//--- verification/pkt2ddr_props.sv
// AXI hold rules and response steering for the bound top level
// checks are off while rst is high
`default_nettype none

module pkt2ddr_props (
    input logic                           clk_sys,
    input logic                           rst,
    input logic                           awvalid,
    input logic                           awready,
    input logic [axi_pkg::AXI_ID_W-1:0]   awid,
    input logic [axi_pkg::AXI_ADDR_W-1:0] awaddr,
    input logic [axi_pkg::AXI_LEN_W-1:0]  awlen,
    input logic [axi_pkg::AXI_SIZE_W-1:0] awsize,
    input logic                           wvalid,
    input logic                           wready,
    input logic [axi_pkg::AXI_DATA_W-1:0] wdata,
    input logic                           bvalid,
    input logic                           bready,
    input logic [axi_pkg::AXI_ID_W-1:0]   bid,
    input logic                           tx_bvalid,
    input logic                           kernel_bvalid
);
    timeunit 1ns;
    timeprecision 1ns;

    aw_hold: assert property (@(posedge clk_sys) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable({awid, awaddr, awlen, awsize}))
        else $error("AW request dropped or changed before awready");

    w_hold: assert property (@(posedge clk_sys) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W beat dropped or changed before wready");

    // one source per response
    b_onehot: assert property (@(posedge clk_sys) disable iff (rst)
        !(tx_bvalid && kernel_bvalid))
        else $error("tx_bvalid and kernel_bvalid high together");

    // ids 0 to 7 belong to tx
    b_follow: assert property (@(posedge clk_sys) disable iff (rst)
        bvalid && bready |=>
            (($past(bid) < 8) ? (tx_bvalid && !kernel_bvalid)
                              : (kernel_bvalid && !tx_bvalid)))
        else $error("B handshake not followed by a bvalid pulse on the source of its bid");

endmodule

bind pkt2ddr_top pkt2ddr_props u_props (.*);

`default_nettype wire

//--- verification/tb_pkt2ddr.sv
// random two-source traffic checked against a queue model and a randomly stalling AXI slave
// a forced awready stall mid-run must push the afull flags high without losing packets
`default_nettype none

module tb_pkt2ddr;
    timeunit 1ns;
    timeprecision 1ns;

    import pkt_pkg::*;
    import axi_pkg::*;

    localparam int N_PKT     = 60;
    localparam int STALL_ON  = 100;
    localparam int STALL_OFF = 400;
    localparam int DRAIN_MAX = 20000;

    logic                  clk_sys;
    logic                  rst;
    logic [1:0]            cmd_wr;
    logic [CMD_W-1:0]      cmd_data [2];
    logic [1:0]            dat_wr;
    logic [DAT_W-1:0]      dat_data [2];
    wire  [1:0]            cmd_afull;
    wire  [1:0]            dat_afull;
    logic                  tx_bvalid;
    logic [AXI_ID_W-1:0]   tx_bid;
    logic [AXI_RESP_W-1:0] tx_bresp;
    logic                  kernel_bvalid;
    logic [AXI_ID_W-1:0]   kernel_bid;
    logic [AXI_RESP_W-1:0] kernel_bresp;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_ID_W-1:0]   awid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic [AXI_LEN_W-1:0]  awlen;
    logic [AXI_SIZE_W-1:0] awsize;
    logic                  wvalid;
    logic                  wready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wlast;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ID_W-1:0]   bid;
    logic [AXI_RESP_W-1:0] bresp;

    // reference model state
    logic [31:0]           lfsr;
    logic [CMD_W-1:0]      cmd_q [2][$];
    logic [DAT_W-1:0]      beat_q [2][$];
    logic [DAT_W-1:0]      drv_q [2][$];
    logic [DAT_W-1:0]      w_q [$];
    logic [AXI_ID_W-1:0]   b_q [$];
    int                    prod_cnt [2];
    int                    resp_cnt;
    int                    pkt_cnt;
    int                    cyc;
    int                    errors;
    int                    checks;
    int                    timer;
    int                    s;
    logic                  run;
    logic                  stalled;
    logic                  afull_seen;
    logic                  b_pend;
    logic [AXI_ID_W-1:0]   pend_bid;
    logic [AXI_RESP_W-1:0] pend_bresp;
    logic [AXI_ID_W-1:0]   burst_id;
    logic [CMD_W-1:0]      cmd;
    logic [DAT_W-1:0]      beat;

    pkt2ddr_top uut (
        .clk_sys          (clk_sys),
        .rst              (rst),
        .tx_cmd_wr        (cmd_wr[0]),
        .tx_cmd_data      (cmd_data[0]),
        .tx_dat_wr        (dat_wr[0]),
        .tx_dat_data      (dat_data[0]),
        .tx_cmd_afull     (cmd_afull[0]),
        .tx_dat_afull     (dat_afull[0]),
        .tx_bvalid        (tx_bvalid),
        .tx_bid           (tx_bid),
        .tx_bresp         (tx_bresp),
        .kernel_cmd_wr    (cmd_wr[1]),
        .kernel_cmd_data  (cmd_data[1]),
        .kernel_dat_wr    (dat_wr[1]),
        .kernel_dat_data  (dat_data[1]),
        .kernel_cmd_afull (cmd_afull[1]),
        .kernel_dat_afull (dat_afull[1]),
        .kernel_bvalid    (kernel_bvalid),
        .kernel_bid       (kernel_bid),
        .kernel_bresp     (kernel_bresp),
        .awvalid          (awvalid),
        .awready          (awready),
        .awid             (awid),
        .awaddr           (awaddr),
        .awlen            (awlen),
        .awsize           (awsize),
        .wvalid           (wvalid),
        .wready           (wready),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .wlast            (wlast),
        .bvalid           (bvalid),
        .bready           (bready),
        .bid              (bid),
        .bresp            (bresp)
    );

    always #50 clk_sys = ~clk_sys;

    // ************************************************************************
    // helpers
    // ************************************************************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = state >> 1;
        if (state[0]) begin
            lfsr_next = lfsr_next ^ 32'h8020_0003;
        end
    endfunction

    // one LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int width);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < width; i++) begin
            lfsr   = lfsr_next(lfsr);
            val[i] = lfsr[0];
        end
        return val;
    endfunction

    // full word except a short end beat
    function automatic logic [3:0] strb_for(input logic [DAT_W-1:0] b);
        if (!b[EOP_BIT] || b[RES_LSB +: RES_W] == 0) begin
            return 4'hf;
        end
        return 4'hf >> (4 - b[RES_LSB +: RES_W]);
    endfunction

    function automatic logic drained();
        return prod_cnt[0] == N_PKT && prod_cnt[1] == N_PKT &&
               cmd_q[0].size() == 0 && cmd_q[1].size() == 0 &&
               beat_q[0].size() == 0 && beat_q[1].size() == 0 &&
               w_q.size() == 0 && b_q.size() == 0 && !b_pend && resp_cnt == 2 * N_PKT;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    // drives the command now and queues its beats
    task automatic new_packet(input int src);
        int               beats;
        logic [CMD_W-1:0] word;
        logic [DAT_W-1:0] b;
        beats = int'(rand_bits(2)) + 1;
        word  = '0;
        word[CMD_ADDR_LSB +: CMD_ADDR_W] = CMD_ADDR_W'(rand_bits(CMD_ADDR_W));
        word[CMD_ID_LSB +: CMD_ID_W]     = 4'(src * 8) | 4'(rand_bits(3));
        word[CMD_SIZE_LSB +: CMD_SIZE_W] = 3'd2;
        word[CMD_LEN_LSB +: CMD_LEN_W]   = 8'(beats - 1);
        cmd_wr[src]   = 1'b1;
        cmd_data[src] = word;
        cmd_q[src].push_back(word);
        for (int i = 0; i < beats; i++) begin
            // start bit left random since the buffer rebuilds it
            b          = DAT_W'(rand_bits(DAT_W));
            b[EOP_BIT] = (i == beats - 1);
            drv_q[src].push_back(b);
            beat_q[src].push_back(b);
        end
        prod_cnt[src]++;
    endtask

    // ************************************************************************
    // producers, AXI slave and output checks on the falling edge
    // ************************************************************************
    always @(negedge clk_sys) begin
        if (run) begin
            cyc++;
            stalled = (cyc >= STALL_ON) && (cyc < STALL_OFF);
            if (stalled && |{cmd_afull, dat_afull}) begin
                afull_seen = 1'b1;
            end

            // routed response of last cycle's B handshake
            check_eq("tx_bvalid", tx_bvalid, b_pend && (pend_bid < 8));
            check_eq("kernel_bvalid", kernel_bvalid, b_pend && (pend_bid >= 8));
            if (b_pend) begin
                check_eq("tx_bid", tx_bid, pend_bid);
                check_eq("kernel_bid", kernel_bid, pend_bid);
                check_eq("tx_bresp", tx_bresp, pend_bresp);
                check_eq("kernel_bresp", kernel_bresp, pend_bresp);
                resp_cnt++;
            end

            // B answers finished bursts in AW order
            b_pend = 1'b0;
            bvalid = 1'b0;
            if (b_q.size() > 0 && bready && rand_bits(1)) begin
                pend_bid   = b_q.pop_front();
                pend_bresp = AXI_RESP_W'(rand_bits(AXI_RESP_W));
                bvalid     = 1'b1;
                bid        = pend_bid;
                bresp      = pend_bresp;
                b_pend     = 1'b1;
            end

            awready = !stalled && rand_bits(1);
            wready  = rand_bits(1);
            if (awvalid && awready) begin
                s = (awid < 8) ? 0 : 1;
                check_true(w_q.size() == 0, "AW accepted before the previous burst ended");
                check_true(cmd_q[s].size() > 0, "AW accepted with no packet pending for its id");
                if (cmd_q[s].size() > 0) begin
                    cmd = cmd_q[s].pop_front();
                    check_eq("awid", awid, cmd[CMD_ID_LSB +: CMD_ID_W]);
                    check_eq("awaddr", awaddr, 64'(cmd[CMD_ADDR_LSB +: CMD_ADDR_W]));
                    check_eq("awlen", awlen, cmd[CMD_LEN_LSB +: CMD_LEN_W]);
                    check_eq("awsize", awsize, cmd[CMD_SIZE_LSB +: CMD_SIZE_W]);
                    for (int i = 0; i <= int'(cmd[CMD_LEN_LSB +: CMD_LEN_W]); i++) begin
                        w_q.push_back(beat_q[s].pop_front());
                    end
                    burst_id = awid;
                end
            end
            if (wvalid && wready) begin
                check_true(w_q.size() > 0, "W beat accepted outside any burst");
                if (w_q.size() > 0) begin
                    beat = w_q.pop_front();
                    check_eq("wdata", wdata, beat[PAYLOAD_W-1:0]);
                    check_eq("wlast", wlast, beat[EOP_BIT]);
                    check_eq("wstrb", wstrb, strb_for(beat));
                    if (beat[EOP_BIT]) begin
                        b_q.push_back(burst_id);
                        pkt_cnt++;
                    end
                end
            end

            for (int src = 0; src < 2; src++) begin
                cmd_wr[src] = 1'b0;
                dat_wr[src] = 1'b0;
                if (drv_q[src].size() > 0) begin
                    if (!dat_afull[src]) begin
                        dat_wr[src]   = 1'b1;
                        dat_data[src] = drv_q[src].pop_front();
                    end
                end else if (prod_cnt[src] < N_PKT && !cmd_afull[src] && !dat_afull[src] &&
                             (stalled || rand_bits(1))) begin
                    new_packet(src);
                end
            end
        end
    end

    initial begin
        clk_sys     = 1'b0;
        rst         = 1'b1;
        lfsr        = 32'd42;
        cmd_wr      = '0;
        dat_wr      = '0;
        cmd_data[0] = '0;
        cmd_data[1] = '0;
        dat_data[0] = '0;
        dat_data[1] = '0;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        bid         = '0;
        bresp       = '0;
        prod_cnt[0] = 0;
        prod_cnt[1] = 0;
        resp_cnt    = 0;
        pkt_cnt     = 0;
        cyc         = 0;
        errors      = 0;
        checks      = 0;
        run         = 1'b0;
        stalled     = 1'b0;
        afull_seen  = 1'b0;
        b_pend      = 1'b0;
        pend_bid    = '0;
        pend_bresp  = '0;
        burst_id    = '0;

        repeat (8) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        @(negedge clk_sys);
        // idle outputs before any input
        check_eq("awvalid", awvalid, 0);
        check_eq("wvalid", wvalid, 0);
        check_eq("bready", bready, 0);
        check_eq("tx_bvalid", tx_bvalid, 0);
        check_eq("kernel_bvalid", kernel_bvalid, 0);
        check_eq("cmd_afull", cmd_afull, 0);
        check_eq("dat_afull", dat_afull, 0);

        @(posedge clk_sys);
        run   = 1'b1;
        timer = 0;
        while (!drained() && timer < DRAIN_MAX) begin
            @(posedge clk_sys);
            timer++;
        end
        check_true(drained(), "timed out waiting for all packets and responses");
        check_true(afull_seen, "no afull flag rose during the awready stall");
        check_eq("packet count", pkt_cnt, 2 * N_PKT);

        $display("checks: %0d  errors: %0d  packets: %0d  responses: %0d",
                 checks, errors, pkt_cnt, resp_cnt);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/pkt_pkg.sv
logic/axi_pkg.sv
logic/pkt_ifs.sv
logic/sync_fifo.sv
logic/src_buffer.sv
logic/wr_arbiter.sv
logic/axi_wr_master.sv
logic/resp_router.sv
logic/pkt2ddr_top.sv
verification/pkt2ddr_props.sv
verification/tb_pkt2ddr.sv
